// ==== src/cdd_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Frames are 12 bytes, byte 0 in the low bits of the 96-bit word
// Bytes 8 and 9 of a published command frame carry opcode tallies
//////////////////////////////////////////////////////////////////////

package cdd_pkg;

	// Bytes per status or command frame
	localparam int FRAME_BYTES = 12;

	typedef logic [7:0] cdd_byte_t;
	typedef logic [3:0] byte_index_t;

	// Named view of a command frame
	typedef struct packed {
		cdd_byte_t [1:0] tail;
		cdd_byte_t       tally06;
		cdd_byte_t       tally09;
		cdd_byte_t [7:0] head;
	} cdd_frame_fields_t;

	// One frame, seen as indexed bytes or as named fields
	typedef union packed {
		cdd_byte_t [FRAME_BYTES-1:0] bytes;
		cdd_frame_fields_t           fields;
	} cdd_frame_u;

	// Drive status reported until the first frame arrives
	localparam logic [FRAME_BYTES*8-1:0] STAT_IDLE_FRAME = {
		8'h9A, 8'h03, 8'h04, 8'h00,
		8'h04, 8'h03, 8'h02, 8'h00,
		8'h01, 8'h01, 8'h41, 8'h12
	};

	// Opcodes counted in byte 0 of host commands
	localparam cdd_byte_t CMD_OPC_06 = 8'h06;
	localparam cdd_byte_t CMD_OPC_09 = 8'h09;

endpackage

// ==== src/cdd_byte_if.sv ====
//////////////////////////////////////////////////////////////////////
// Byte hand-off between link control and bit shifter, strobes only
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

interface cdd_byte_if;
	import cdd_pkg::*;

	// Control to shifter
	logic      load;
	cdd_byte_t tx_byte;

	// Shifter to control
	logic      bit_sampled;
	logic      byte_done;
	cdd_byte_t rx_byte;

	modport ctrl (
		output load,
		output tx_byte,
		input  bit_sampled,
		input  byte_done,
		input  rx_byte
	);

	modport shifter (
		input  load,
		input  tx_byte,
		output bit_sampled,
		output byte_done,
		output rx_byte
	);

endinterface

// ==== src/cdd_host_if.sv ====
//////////////////////////////////////////////////////////////////////
// Received host bytes toward the command assembler, no back-pressure
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

interface cdd_host_if;
	import cdd_pkg::*;

	// Byte write by index
	logic        host_we;
	byte_index_t host_index;
	cdd_byte_t   host_byte;

	// One cycle after the last byte write
	logic        frame_done;

	modport ctrl (
		output host_we,
		output host_index,
		output host_byte,
		output frame_done
	);

	modport assembler (
		input  host_we,
		input  host_index,
		input  host_byte,
		input  frame_done
	);

endinterface

// ==== src/cdd_stat_buffer.sv ====
//////////////////////////////////////////////////////////////////////
// stat_frame must be stable when stat_toggle changes level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module cdd_stat_buffer (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic [cdd_pkg::FRAME_BYTES*8-1:0]    stat_frame,
	input  logic                                 stat_toggle,
	output logic                                 stat_new,
	input  cdd_pkg::byte_index_t                 stat_index,
	output cdd_pkg::cdd_byte_t                   stat_byte
);
	import cdd_pkg::*;

	logic       toggle_seen;
	cdd_frame_u stat_q;

	// Capture on any toggle level change
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			toggle_seen <= 1'b0;
			stat_new    <= 1'b0;
			stat_q      <= STAT_IDLE_FRAME;
		end else begin
			stat_new <= 1'b0;
			if (stat_toggle != toggle_seen) begin
				toggle_seen <= stat_toggle;
				stat_q      <= stat_frame;
				stat_new    <= 1'b1;
			end
		end
	end

	// Byte select for the control module
	assign stat_byte = stat_q.bytes[stat_index];

	// Control must never address past the last status byte
	a_stat_index: assert property (
		@(posedge clk_sys) disable iff (reset)
		stat_index < FRAME_BYTES
	) else $error("status byte index out of range");

endmodule

// ==== src/cdd_bit_shifter.sv ====
//////////////////////////////////////////////////////////////////////
// comclk is assumed synchronous to clk_sys and slower than clk_sys/2
// Both directions are LSB first, cdata changes on falling comclk
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module cdd_bit_shifter (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        comclk,
	input  logic        hdata,
	output logic        cdata,
	cdd_byte_if.shifter byte_bus
);
	import cdd_pkg::*;

	logic      comclk_q;
	logic      comclk_rise;
	logic      comclk_fall;
	cdd_byte_t tx_sr;
	cdd_byte_t rx_sr;
	logic [2:0] bit_cnt;

	// Edge detect against the previous comclk level
	assign comclk_rise = comclk & ~comclk_q;
	assign comclk_fall = ~comclk & comclk_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			comclk_q             <= 1'b0;
			cdata                <= 1'b0;
			tx_sr                <= '0;
			bit_cnt              <= '0;
			byte_bus.bit_sampled <= 1'b0;
			byte_bus.byte_done   <= 1'b0;
		end else begin
			comclk_q             <= comclk;
			byte_bus.bit_sampled <= 1'b0;
			byte_bus.byte_done   <= 1'b0;
			if (byte_bus.load) begin
				tx_sr   <= byte_bus.tx_byte;
				bit_cnt <= '0;
			end else begin
				if (comclk_fall) begin
					cdata <= tx_sr[0];
					tx_sr <= {1'b0, tx_sr[7:1]};
				end
				if (comclk_rise) begin
					bit_cnt              <= bit_cnt + 3'd1;
					byte_bus.bit_sampled <= 1'b1;
					byte_bus.byte_done   <= (bit_cnt == 3'd7);
				end
			end
		end
	end

	// Host data in
	always_ff @(posedge clk_sys) begin
		if (comclk_rise && !byte_bus.load) begin
			rx_sr <= {hdata, rx_sr[7:1]};
		end
	end

	assign byte_bus.rx_byte = rx_sr;

	// A new byte is only loaded once the previous one has been taken
	a_load_vs_done: assert property (
		@(posedge clk_sys) disable iff (reset)
		!(byte_bus.load && byte_bus.byte_done)
	) else $error("byte load collides with byte completion");

endmodule

// ==== src/cdd_link_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// START_DELAY and BYTE_GAP must both be 2 or more
// A status change mid-transaction restarts from byte 0
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module cdd_link_ctrl #(
	parameter int START_DELAY = 15,
	parameter int BYTE_GAP    = 1023
) (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 stat_new,
	output cdd_pkg::byte_index_t stat_index,
	input  cdd_pkg::cdd_byte_t   stat_byte,
	cdd_byte_if.ctrl             byte_bus,
	cdd_host_if.ctrl             host_bus,
	output logic                 comreq_n,
	output logic                 comsync_n
);
	import cdd_pkg::*;

	localparam int DELAY_W = $clog2(START_DELAY + 1);
	localparam int GAP_W   = $clog2(BYTE_GAP + 1);

	logic [DELAY_W-1:0] delay_cnt;
	logic [GAP_W-1:0]   gap_cnt;
	byte_index_t        byte_cnt;
	logic               start_fire;
	logic               byte_accept;
	logic               last_byte;

	assign start_fire  = (delay_cnt == DELAY_W'(1));
	assign last_byte   = (byte_cnt == byte_index_t'(FRAME_BYTES - 1));
	// byte_cnt rests at FRAME_BYTES between transactions
	assign byte_accept = byte_bus.byte_done && (byte_cnt < byte_index_t'(FRAME_BYTES));

	// Index of the next status byte to send
	assign stat_index = (start_fire || byte_cnt >= byte_index_t'(FRAME_BYTES - 1)) ?
		'0 : byte_cnt + 4'd1;

	// Start delay, reloaded by every status change
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			delay_cnt <= '0;
		end else if (stat_new) begin
			delay_cnt <= DELAY_W'(START_DELAY - 1);
		end else if (delay_cnt != '0) begin
			delay_cnt <= delay_cnt - 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Transaction sequencing
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			gap_cnt             <= '0;
			byte_cnt            <= byte_index_t'(FRAME_BYTES);
			comreq_n            <= 1'b1;
			comsync_n           <= 1'b1;
			byte_bus.load       <= 1'b0;
			host_bus.host_we    <= 1'b0;
			host_bus.frame_done <= 1'b0;
		end else begin
			byte_bus.load       <= 1'b0;
			host_bus.host_we    <= 1'b0;
			host_bus.frame_done <= host_bus.host_we &&
				(host_bus.host_index == byte_index_t'(FRAME_BYTES - 1));

			// Request goes low at the end of a gap, high on the first bit
			if (gap_cnt != '0)
				gap_cnt <= gap_cnt - 1'b1;
			if (gap_cnt == GAP_W'(1))
				comreq_n <= 1'b0;
			if (byte_bus.bit_sampled)
				comreq_n <= 1'b1;

			if (start_fire) begin
				byte_bus.load <= 1'b1;
				byte_cnt      <= '0;
				gap_cnt       <= GAP_W'(BYTE_GAP);
				comreq_n      <= 1'b1;
				comsync_n     <= 1'b0;
			end else if (byte_accept) begin
				byte_bus.load    <= 1'b1;
				host_bus.host_we <= 1'b1;
				byte_cnt         <= byte_cnt + 4'd1;
				// Gap counts from byte_done, one cycle earlier than this load
				gap_cnt          <= GAP_W'(BYTE_GAP - 1);
				comsync_n        <= 1'b1;
			end
		end
	end

	// Payload toward shifter and assembler
	always_ff @(posedge clk_sys) begin
		if (start_fire) begin
			byte_bus.tx_byte <= stat_byte;
		end else if (byte_accept) begin
			byte_bus.tx_byte    <= last_byte ? '0 : stat_byte;
			host_bus.host_index <= byte_cnt;
			host_bus.host_byte  <= byte_bus.rx_byte;
		end
	end

	// Sync low only from the byte 0 load until its byte_done
	a_sync_window: assert property (
		@(posedge clk_sys) disable iff (reset)
		!comsync_n |-> byte_cnt == '0 && !host_bus.host_we
	) else $error("comsync_n low outside byte 0");

endmodule

// ==== src/cdd_cmd_assembler.sv ====
//////////////////////////////////////////////////////////////////////
// Tallies count earlier frames only and wrap at 256
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module cdd_cmd_assembler (
	input  logic                              clk_sys,
	input  logic                              reset,
	cdd_host_if.assembler                     host_bus,
	output logic [cdd_pkg::FRAME_BYTES*8-1:0] cmd_frame,
	output logic                              cmd_toggle
);
	import cdd_pkg::*;

	cdd_frame_u host_frame;
	cdd_frame_u pub_frame;
	cdd_byte_t  tally06;
	cdd_byte_t  tally09;

	// Host bytes by position
	always_ff @(posedge clk_sys) begin
		if (host_bus.host_we) begin
			host_frame.bytes[host_bus.host_index] <= host_bus.host_byte;
		end
	end

	// Tallies replace bytes 8 and 9
	always_comb begin
		pub_frame                = host_frame;
		pub_frame.fields.tally06 = tally06;
		pub_frame.fields.tally09 = tally09;
	end

	//////////////////////////////////////////////////////////////////////
	// Publish and count
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cmd_frame  <= '0;
			cmd_toggle <= 1'b0;
			tally06    <= '0;
			tally09    <= '0;
		end else if (host_bus.frame_done) begin
			cmd_frame  <= pub_frame;
			cmd_toggle <= ~cmd_toggle;
			if (host_frame.bytes[0] == CMD_OPC_06)
				tally06 <= tally06 + 8'd1;
			if (host_frame.bytes[0] == CMD_OPC_09)
				tally09 <= tally09 + 8'd1;
		end
	end

	// Writes from control stay inside the frame
	a_host_index: assert property (
		@(posedge clk_sys) disable iff (reset)
		host_bus.host_we |-> host_bus.host_index < FRAME_BYTES
	) else $error("host byte index out of range");

endmodule

// ==== src/cdd_link.sv ====
//////////////////////////////////////////////////////////////////////
// Frames handshake by toggle level, drive lines are active low
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module cdd_link #(
	parameter int START_DELAY = 15,
	parameter int BYTE_GAP    = 1023
) (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic [cdd_pkg::FRAME_BYTES*8-1:0] stat_frame,
	input  logic                              stat_toggle,
	input  logic                              comclk,
	input  logic                              hdata,
	output logic                              cdata,
	output logic                              comreq_n,
	output logic                              comsync_n,
	output logic [cdd_pkg::FRAME_BYTES*8-1:0] cmd_frame,
	output logic                              cmd_toggle
);
	import cdd_pkg::*;

	cdd_byte_if byte_bus ();
	cdd_host_if host_bus ();

	logic        stat_new;
	byte_index_t stat_index;
	cdd_byte_t   stat_byte;

	cdd_stat_buffer u_stat_buffer (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.stat_frame  (stat_frame),
		.stat_toggle (stat_toggle),
		.stat_new    (stat_new),
		.stat_index  (stat_index),
		.stat_byte   (stat_byte)
	);

	cdd_bit_shifter u_bit_shifter (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.comclk   (comclk),
		.hdata    (hdata),
		.cdata    (cdata),
		.byte_bus (byte_bus.shifter)
	);

	cdd_link_ctrl #(
		.START_DELAY (START_DELAY),
		.BYTE_GAP    (BYTE_GAP)
	) u_link_ctrl (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.stat_new   (stat_new),
		.stat_index (stat_index),
		.stat_byte  (stat_byte),
		.byte_bus   (byte_bus.ctrl),
		.host_bus   (host_bus.ctrl),
		.comreq_n   (comreq_n),
		.comsync_n  (comsync_n)
	);

	cdd_cmd_assembler u_cmd_assembler (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.host_bus   (host_bus.assembler),
		.cmd_frame  (cmd_frame),
		.cmd_toggle (cmd_toggle)
	);

endmodule

// ==== test/tb_cdd_link.sv ====
//////////////////////////////////////////////////////////////////////
// Host model idles comclk high, 6 clk_sys per bit, cdata read before rise
// All inputs change and all outputs are sampled on the falling clk_sys edge
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_cdd_link;
	import cdd_pkg::*;

	localparam int START_DELAY     = 15;
	localparam int BYTE_GAP        = 40;
	localparam int FRAMES_FIRST    = 20;
	localparam int FRAMES_SECOND   = 12;
	localparam int NUM_FRAMES      = FRAMES_FIRST + FRAMES_SECOND;
	localparam int WATCHDOG_CYCLES = NUM_FRAMES * FRAME_BYTES * (BYTE_GAP + 60) * 2;
	// comclk low and high phase length in clk_sys cycles
	localparam int HALF_BIT        = 3;

	logic                      clk_sys;
	logic                      reset;
	logic [FRAME_BYTES*8-1:0]  stat_frame;
	logic                      stat_toggle;
	logic                      comclk;
	logic                      hdata;
	logic                      cdata;
	logic                      comreq_n;
	logic                      comsync_n;
	logic [FRAME_BYTES*8-1:0]  cmd_frame;
	logic                      cmd_toggle;

	integer seed;
	int     errors;
	int     checks;
	// Reference tallies of earlier frames
	int     tally06_m;
	int     tally09_m;
	// Reference command toggle level
	logic   toggle_m;

	cdd_link #(
		.START_DELAY (START_DELAY),
		.BYTE_GAP    (BYTE_GAP)
	) DUT (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.stat_frame  (stat_frame),
		.stat_toggle (stat_toggle),
		.comclk      (comclk),
		.hdata       (hdata),
		.cdata       (cdata),
		.comreq_n    (comreq_n),
		.comsync_n   (comsync_n),
		.cmd_frame   (cmd_frame),
		.cmd_toggle  (cmd_toggle)
	);

	initial clk_sys = 1'b0;
	always #5 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////////////////////////
	// Checks and random helpers
	//////////////////////////////////////////////////////////////////////

	task automatic check_byte(input string name, input cdd_byte_t expected,
		input cdd_byte_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	function automatic cdd_byte_t random_byte();
		return 8'($random(seed));
	endfunction

	// Half of all commands start with one of the tallied opcodes
	function automatic cdd_byte_t pick_opcode();
		int pick;
		pick = $random(seed) & 3;
		if (pick == 0)
			return CMD_OPC_06;
		else if (pick == 1)
			return CMD_OPC_09;
		else
			return random_byte();
	endfunction

	task automatic apply_reset();
		int k;
		reset       = 1'b1;
		stat_toggle = 1'b0;
		comclk      = 1'b1;
		hdata       = 1'b0;
		repeat (5) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		check_bit("reset comreq_n", 1'b1, comreq_n);
		check_bit("reset comsync_n", 1'b1, comsync_n);
		check_bit("reset cdata", 1'b0, cdata);
		check_bit("reset cmd_toggle", 1'b0, cmd_toggle);
		for (k = 0; k < FRAME_BYTES; k++)
			check_byte($sformatf("reset cmd_frame byte %0d", k), 8'h00, cmd_frame[k*8 +: 8]);
		tally06_m = 0;
		tally09_m = 0;
		toggle_m  = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Host side of the serial link
	//////////////////////////////////////////////////////////////////////

	// One byte each way, LSB first, sync level checked on every bit
	task automatic exchange_byte(input int idx, input cdd_byte_t host_byte,
		output cdd_byte_t drive_byte);
		logic exp_sync;
		int   i;
		exp_sync   = (idx != 0);
		drive_byte = '0;
		for (i = 0; i < 8; i++) begin
			comclk = 1'b0;
			hdata  = host_byte[i];
			repeat (HALF_BIT) @(negedge clk_sys);
			drive_byte[i] = cdata;
			check_bit($sformatf("comsync_n byte %0d bit %0d", idx, i), exp_sync, comsync_n);
			comclk = 1'b1;
			repeat (HALF_BIT) @(negedge clk_sys);
		end
	endtask

	task automatic run_frame(input int frame_no);
		logic [FRAME_BYTES*8-1:0] frame;
		cdd_byte_t                host [FRAME_BYTES];
		cdd_byte_t                got;
		cdd_byte_t                expected;
		logic                     toggle_before;
		int                       b;
		for (b = 0; b < FRAME_BYTES; b++)
			frame[b*8 +: 8] = random_byte();
		host[0] = pick_opcode();
		for (b = 1; b < FRAME_BYTES; b++)
			host[b] = random_byte();

		toggle_before = toggle_m;
		stat_frame    = frame;
		stat_toggle   = ~stat_toggle;

		// Sync low marks the start, the request may still be low from the last gap
		while (comsync_n !== 1'b0)
			@(negedge clk_sys);
		for (b = 0; b < FRAME_BYTES; b++) begin
			while (comreq_n !== 1'b0)
				@(negedge clk_sys);
			exchange_byte(b, host[b], got);
			check_byte($sformatf("status frame %0d byte %0d", frame_no, b),
				frame[b*8 +: 8], got);
		end
		check_bit($sformatf("cmd_toggle early flip frame %0d", frame_no),
			toggle_before, cmd_toggle);

		while (cmd_toggle === toggle_before)
			@(negedge clk_sys);
		repeat (4) @(negedge clk_sys);
		check_bit($sformatf("cmd_toggle single flip frame %0d", frame_no),
			~toggle_before, cmd_toggle);
		toggle_m = ~toggle_before;

		// Bytes 8 and 9 carry the tallies of earlier frames
		for (b = 0; b < FRAME_BYTES; b++) begin
			if (b == 9)
				expected = 8'(tally06_m);
			else if (b == 8)
				expected = 8'(tally09_m);
			else
				expected = host[b];
			check_byte($sformatf("command frame %0d byte %0d", frame_no, b),
				expected, cmd_frame[b*8 +: 8]);
		end
		if (host[0] == CMD_OPC_06)
			tally06_m = (tally06_m + 1) % 256;
		if (host[0] == CMD_OPC_09)
			tally09_m = (tally09_m + 1) % 256;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		int f;
		seed        = 79014;
		errors      = 0;
		checks      = 0;
		tally06_m   = 0;
		tally09_m   = 0;
		toggle_m    = 1'b0;
		reset       = 1'b1;
		stat_frame  = '0;
		stat_toggle = 1'b0;
		comclk      = 1'b1;
		hdata       = 1'b0;

		apply_reset();
		for (f = 0; f < FRAMES_FIRST; f++)
			run_frame(f);

		// Tallies must restart after a second reset
		apply_reset();
		for (f = 0; f < FRAMES_SECOND; f++)
			run_frame(FRAMES_FIRST + f);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles, the link stopped responding",
			WATCHDOG_CYCLES);
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("Done: errors found");
		$finish;
	end

endmodule

// ==== cdd_link.f ====
src/cdd_pkg.sv
src/cdd_byte_if.sv
src/cdd_host_if.sv
src/cdd_stat_buffer.sv
src/cdd_bit_shifter.sv
src/cdd_link_ctrl.sv
src/cdd_cmd_assembler.sv
src/cdd_link.sv
test/tb_cdd_link.sv

// ==== Bender.yml ====
package:
  name: cdd_link

sources:
  - src/cdd_pkg.sv
  - src/cdd_byte_if.sv
  - src/cdd_host_if.sv
  - src/cdd_stat_buffer.sv
  - src/cdd_bit_shifter.sv
  - src/cdd_link_ctrl.sv
  - src/cdd_cmd_assembler.sv
  - src/cdd_link.sv
  - target: test
    files:
      - test/tb_cdd_link.sv
